// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -f list.f --top-module tb_bus_subsystem -Mdir obj_dir -o vsim
	@out="$$(./obj_dir/vsim)"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== list.f ====
src/bus_ctrl_pkg.sv
src/bus_map_pkg.sv
src/bus_arbiter.sv
src/slave_select.sv
src/wait_state_regs.sv
src/internal_ram.sv
src/bus_subsystem.sv
sim/clock_gen.sv
sim/tb_bus_subsystem.sv

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset_n
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock; // 10 ns period
  end

  initial begin
    reset_n <= 1'b0;
    repeat (10) @(posedge clock);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_bus_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsystem;

  localparam int TIMEOUT_CYCLES = 64;
  localparam int NUM_WORDS = 8;
  localparam bus_ctrl_pkg::addr_t REG0_ADDR = 32'h0080_0C00;
  localparam bus_ctrl_pkg::addr_t REG1_ADDR = 32'h0080_0C04;
  localparam bus_ctrl_pkg::addr_t UNMAPPED_BASE = 32'h0040_0000;

  logic                clock;
  logic                reset_n;
  bus_ctrl_pkg::addr_t cpu_address;
  logic                cpu_read;
  logic                cpu_write;
  bus_ctrl_pkg::be_t   cpu_be;
  bus_ctrl_pkg::word_t cpu_writedata;
  bus_ctrl_pkg::addr_t vga_address;
  logic                vga_read;
  logic                cpu_wait;
  logic                vga_wait;
  bus_ctrl_pkg::word_t cpu_readdata;
  bus_ctrl_pkg::word_t vga_readdata;

  bus_ctrl_pkg::word_t       model_ram [4096];
  bus_ctrl_pkg::wait_count_t model_regs [2];
  bus_ctrl_pkg::addr_t       ram_addr [NUM_WORDS];
  bus_ctrl_pkg::word_t       cpu_expect;
  bus_ctrl_pkg::word_t       vga_expect;
  logic [15:0]               lfsr_state = 16'd94;

  int   checks = 0;
  int   errors = 0;
  int   timeouts = 0;
  int   read_checks = 0;
  int   read_errors = 0;
  int   cpu_reads_issued = 0;
  int   vga_reads_issued = 0;
  int   cpu_reads_seen = 0;
  int   vga_reads_seen = 0;
  logic cpu_checked = 1'b0;
  logic vga_checked = 1'b0;

  clock_gen i_clock_gen (
    .clock   (clock),
    .reset_n (reset_n)
  );

  bus_subsystem i_dut (
    .clock         (clock),
    .reset_n       (reset_n),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_be        (cpu_be),
    .cpu_writedata (cpu_writedata),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .cpu_wait      (cpu_wait),
    .vga_wait      (vga_wait),
    .cpu_readdata  (cpu_readdata),
    .vga_readdata  (vga_readdata)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Reference model of the address map and the slaves
  function automatic bus_ctrl_pkg::word_t expected_read(input bus_ctrl_pkg::addr_t a);
    if (a <= bus_map_pkg::RAM_LAST)
      return model_ram[a[13:2]];
    if (a >= bus_map_pkg::WAIT_REGS_BASE && a <= bus_map_pkg::WAIT_REGS_LAST)
      return {28'h0, model_regs[a[2]]};
    return '0; // Unmapped
  endfunction

  function automatic int expected_latency(input bus_ctrl_pkg::addr_t a);
    if (a <= bus_map_pkg::RAM_LAST)
      return int'(model_regs[0]) + 3;
    return int'(model_regs[1]) + 3;
  endfunction

  function automatic void model_write(input bus_ctrl_pkg::addr_t a, input bus_ctrl_pkg::be_t be,
                                      input bus_ctrl_pkg::word_t d);
    if (a <= bus_map_pkg::RAM_LAST) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b])
          model_ram[a[13:2]][8*b +: 8] = d[8*b +: 8];
      end
    end else if (a >= bus_map_pkg::WAIT_REGS_BASE && a <= bus_map_pkg::WAIT_REGS_LAST && be[0]) begin
      model_regs[a[2]] = d[3:0];
    end
  endfunction

  task automatic check_word(input string name, input bus_ctrl_pkg::word_t got,
                            input bus_ctrl_pkg::word_t exp);
    read_checks++;
    if (got !== exp) begin
      read_errors++;
      $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR t=%0t %s latency: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Counts edges from the one that samples the request
  task automatic wait_for_done(input logic is_vga, output int cycles);
    logic  waiting;
    string who;
    cycles = 0;
    waiting = 1'b1;
    while (waiting && cycles < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycles++;
      @(negedge clock);
      waiting = is_vga ? vga_wait : cpu_wait;
    end
    if (waiting) begin
      if (is_vga)
        who = "display";
      else
        who = "CPU";
      timeouts++;
      $display("Timeout: the %s master was still waiting after %0d cycles", who, TIMEOUT_CYCLES);
    end
  endtask

  task automatic cpu_transfer(input bus_ctrl_pkg::addr_t a, input logic is_write,
                              input bus_ctrl_pkg::be_t be, input bus_ctrl_pkg::word_t data);
    int cycles;
    int expected_cycles;
    expected_cycles = expected_latency(a);
    cpu_expect = expected_read(a);
    if (!is_write)
      cpu_reads_issued++;
    @(posedge clock);
    cpu_address   <= a;
    cpu_read      <= !is_write;
    cpu_write     <= is_write;
    cpu_be        <= be;
    cpu_writedata <= data;
    wait_for_done(1'b0, cycles);
    if (is_write)
      model_write(a, be, data);
    check_latency("cpu_wait", cycles, expected_cycles);
    @(posedge clock);
    cpu_read  <= 1'b0;
    cpu_write <= 1'b0;
    @(posedge clock); // Request low for one cycle
  endtask

  task automatic vga_transfer(input bus_ctrl_pkg::addr_t a);
    int cycles;
    int expected_cycles;
    expected_cycles = expected_latency(a);
    vga_expect = expected_read(a);
    vga_reads_issued++;
    @(posedge clock);
    vga_address <= a;
    vga_read    <= 1'b1;
    wait_for_done(1'b1, cycles);
    check_latency("vga_wait", cycles, expected_cycles);
    @(posedge clock);
    vga_read <= 1'b0;
    @(posedge clock);
  endtask

  // Both masters request on the same edge
  task automatic race_transfer(input bus_ctrl_pkg::addr_t a_cpu, input bus_ctrl_pkg::addr_t a_vga);
    int cycles;
    int cpu_cycles;
    int vga_cycles;
    cpu_cycles = expected_latency(a_cpu);
    vga_cycles = expected_latency(a_vga) + 1; // One extra cycle for POST to IDLE
    cpu_expect = expected_read(a_cpu);
    vga_expect = expected_read(a_vga);
    cpu_reads_issued++;
    vga_reads_issued++;
    @(posedge clock);
    cpu_address <= a_cpu;
    cpu_be      <= 4'hF;
    cpu_read    <= 1'b1;
    vga_address <= a_vga;
    vga_read    <= 1'b1;
    wait_for_done(1'b0, cycles);
    check_level("vga_wait", vga_wait, 1'b1);
    check_latency("cpu_wait", cycles, cpu_cycles);
    @(posedge clock);
    cpu_read <= 1'b0;
    wait_for_done(1'b1, cycles);
    check_latency("vga_wait", cycles, vga_cycles);
    @(posedge clock);
    vga_read <= 1'b0;
    @(posedge clock);
  endtask

  // Request dropped while the arbiter is in PRE
  task automatic aborted_read(input bus_ctrl_pkg::addr_t a);
    @(posedge clock);
    cpu_address <= a;
    cpu_be      <= 4'hF;
    cpu_read    <= 1'b1;
    @(posedge clock);
    @(negedge clock);
    check_level("cpu_wait", cpu_wait, 1'b1);
    @(posedge clock);
    cpu_read <= 1'b0;
    repeat (2) begin
      @(negedge clock);
      check_level("cpu_wait", cpu_wait, 1'b1);
      @(posedge clock);
    end
  endtask

  // Read data monitor, one check per completed read
  always @(negedge clock) begin
    if (reset_n === 1'b1) begin
      if (cpu_wait === 1'b0 && vga_wait === 1'b0) begin
        read_errors++;
        $display("Both masters were released in the same cycle at t=%0t", $time);
      end
      if (cpu_read === 1'b1 && cpu_wait === 1'b0 && !cpu_checked) begin
        check_word("cpu_readdata", cpu_readdata, cpu_expect);
        cpu_checked = 1'b1;
        cpu_reads_seen++;
      end
      if (cpu_read !== 1'b1)
        cpu_checked = 1'b0;
      if (vga_read === 1'b1 && vga_wait === 1'b0 && !vga_checked) begin
        check_word("vga_readdata", vga_readdata, vga_expect);
        vga_checked = 1'b1;
        vga_reads_seen++;
      end
      if (vga_read !== 1'b1)
        vga_checked = 1'b0;
    end
  end

  initial begin : main_sequence
    int n;
    cpu_address   <= '0;
    cpu_read      <= 1'b0;
    cpu_write     <= 1'b0;
    cpu_be        <= '0;
    cpu_writedata <= '0;
    vga_address   <= '0;
    vga_read      <= 1'b0;
    model_regs[0] = bus_ctrl_pkg::wait_count_t'(bus_map_pkg::RAM_WAIT_RESET);
    model_regs[1] = bus_ctrl_pkg::wait_count_t'(bus_map_pkg::REGS_WAIT_RESET);

    n = 0;
    while (reset_n !== 1'b1 && n < 50) begin
      @(posedge clock);
      n++;
    end
    if (reset_n !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end

    repeat (5) begin // Idle bus
      @(negedge clock);
      check_level("cpu_wait", cpu_wait, 1'b1);
      check_level("vga_wait", vga_wait, 1'b1);
    end

    for (int i = 0; i < NUM_WORDS; i++) begin
      ram_addr[i] = {18'h0, 12'(random_bits(12)), 2'b00};
      cpu_transfer(ram_addr[i], 1'b1, 4'hF, random_bits(32));
    end
    for (int i = 0; i < NUM_WORDS; i++)
      cpu_transfer(ram_addr[i], 1'b1, 4'(random_bits(4)), random_bits(32));
    for (int i = 0; i < NUM_WORDS; i++) begin
      cpu_transfer(ram_addr[i], 1'b0, 4'hF, '0);
      vga_transfer(ram_addr[i]);
    end

    // New wait counts for both regions
    cpu_transfer(REG0_ADDR, 1'b1, 4'hF, random_bits(3));
    cpu_transfer(REG1_ADDR, 1'b1, 4'hF, random_bits(2));
    for (int i = 0; i < 4; i++) begin
      cpu_transfer(ram_addr[i], 1'b0, 4'hF, '0);
      vga_transfer(ram_addr[i + 4]);
    end
    cpu_transfer(REG0_ADDR, 1'b0, 4'hF, '0);
    cpu_transfer(REG1_ADDR, 1'b0, 4'hF, '0);
    vga_transfer(REG0_ADDR);

    race_transfer(ram_addr[0], ram_addr[1]);
    race_transfer(REG1_ADDR, ram_addr[2]);

    // Unmapped addresses alias the RAM and register index bits
    cpu_transfer(UNMAPPED_BASE, 1'b0, 4'hF, '0);
    vga_transfer(UNMAPPED_BASE + 32'h4);
    cpu_transfer(UNMAPPED_BASE | ram_addr[0], 1'b1, 4'hF, random_bits(32));
    cpu_transfer(UNMAPPED_BASE | 32'h0000_0C00, 1'b1, 4'hF, random_bits(32));
    cpu_transfer(ram_addr[0], 1'b0, 4'hF, '0);
    cpu_transfer(REG0_ADDR, 1'b0, 4'hF, '0);
    cpu_transfer(REG1_ADDR, 1'b0, 4'hF, '0);

    aborted_read(ram_addr[3]);
    vga_transfer(ram_addr[3]);

    repeat (2) @(posedge clock);
    if (cpu_reads_seen != cpu_reads_issued || vga_reads_seen != vga_reads_issued) begin
      errors++;
      $display("Read completions do not match: CPU %0d of %0d, display %0d of %0d",
               cpu_reads_seen, cpu_reads_issued, vga_reads_seen, vga_reads_issued);
    end

    $display("Checks %0d, errors %0d, read checks %0d, read errors %0d, timeouts %0d",
             checks, errors, read_checks, read_errors, timeouts);
    if (errors == 0 && read_errors == 0 && timeouts == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic                      clock,
  input  logic                      reset_n,
  input  bus_ctrl_pkg::addr_t       cpu_address,
  input  logic                      cpu_read,
  input  logic                      cpu_write,
  input  bus_ctrl_pkg::be_t         cpu_be,
  input  bus_ctrl_pkg::word_t       cpu_writedata,
  input  bus_ctrl_pkg::addr_t       vga_address,
  input  logic                      vga_read,
  input  bus_ctrl_pkg::wait_count_t wait_cycles,
  output bus_ctrl_pkg::addr_t       address,
  output logic                      read,
  output logic                      write,
  output bus_ctrl_pkg::be_t         be,
  output bus_ctrl_pkg::word_t       writedata,
  output logic                      start,
  output logic                      bus_active,
  output logic                      cpu_wait,
  output logic                      vga_wait
);

  bus_ctrl_pkg::arb_state_t  state, state_next;
  bus_ctrl_pkg::master_t     grant, grant_next;
  bus_ctrl_pkg::wait_count_t delay, delay_next;
  logic                      cpu_request;
  logic                      granted_request;

  assign cpu_request = cpu_read | cpu_write;

  // Granted master still holds its request
  assign granted_request = (grant[bus_ctrl_pkg::MASTER_CPU] & cpu_request) |
                           (grant[bus_ctrl_pkg::MASTER_VGA] & vga_read);

  always_comb begin
    address   = '0;
    read      = 1'b0;
    write     = 1'b0;
    be        = '0;
    writedata = '0;
    if (grant[bus_ctrl_pkg::MASTER_CPU]) begin
      address   = cpu_address;
      read      = cpu_read;
      write     = cpu_write;
      be        = cpu_be;
      writedata = cpu_writedata;
    end else if (grant[bus_ctrl_pkg::MASTER_VGA]) begin
      address = vga_address;
      read    = vga_read;
      be      = '1; // Display always fetches whole words
    end
  end

  assign start      = (state == bus_ctrl_pkg::START);
  assign bus_active = (state != bus_ctrl_pkg::IDLE);
  assign cpu_wait   = grant[bus_ctrl_pkg::MASTER_CPU] ? (state != bus_ctrl_pkg::POST) : 1'b1;
  assign vga_wait   = grant[bus_ctrl_pkg::MASTER_VGA] ? (state != bus_ctrl_pkg::POST) : 1'b1;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= bus_ctrl_pkg::IDLE;
      grant <= '0;
      delay <= '0;
    end else begin
      state <= state_next;
      grant <= grant_next;
      delay <= delay_next;
    end
  end

  always_comb begin
    state_next = state;
    grant_next = grant;
    delay_next = delay;
    case (state)
      bus_ctrl_pkg::IDLE: begin
        if (cpu_request) begin // CPU has priority
          grant_next = '0;
          grant_next[bus_ctrl_pkg::MASTER_CPU] = 1'b1;
          state_next = bus_ctrl_pkg::START;
        end else if (vga_read) begin
          grant_next = '0;
          grant_next[bus_ctrl_pkg::MASTER_VGA] = 1'b1;
          state_next = bus_ctrl_pkg::START;
        end
      end
      bus_ctrl_pkg::START: begin
        if (granted_request) begin
          delay_next = wait_cycles; // Region's wait count, sampled once
          state_next = bus_ctrl_pkg::PRE;
        end else begin
          grant_next = '0;
          state_next = bus_ctrl_pkg::IDLE;
        end
      end
      bus_ctrl_pkg::PRE: begin
        if (!granted_request) begin // Aborted by master
          delay_next = '0;
          grant_next = '0;
          state_next = bus_ctrl_pkg::IDLE;
        end else if (delay == '0) begin
          state_next = bus_ctrl_pkg::POST;
        end else begin
          delay_next = delay - bus_ctrl_pkg::wait_count_t'(1);
        end
      end
      bus_ctrl_pkg::POST: begin
        if (!granted_request) begin
          grant_next = '0;
          state_next = bus_ctrl_pkg::IDLE;
        end
      end
      default: begin
        grant_next = '0;
        state_next = bus_ctrl_pkg::IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/bus_ctrl_pkg.sv ====
`default_nettype none

package bus_ctrl_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t; // Byte address
  typedef logic [3:0]  be_t;

  // Wait cycles spent in PRE
  typedef logic [3:0] wait_count_t;

  typedef logic [1:0] master_t; // One-hot grant

  localparam int MASTER_CPU = 0;
  localparam int MASTER_VGA = 1;

  typedef enum logic [1:0] {
    IDLE,
    START,
    PRE,
    POST
  } arb_state_t;

endpackage

`default_nettype wire

// ==== src/bus_map_pkg.sv ====
`default_nettype none

package bus_map_pkg;

  typedef logic [1:0] chip_select_t; // One-hot, one bit per slave

  localparam int CS_RAM       = 0;
  localparam int CS_WAIT_REGS = 1;

  // Internal RAM, 4k words
  localparam logic [31:0] RAM_BASE = 32'h0000_0000;
  localparam logic [31:0] RAM_LAST = 32'h0000_3FFF;
  localparam int          RAM_WORDS = 4096;

  localparam logic [31:0] WAIT_REGS_BASE = 32'h0080_0C00;
  localparam logic [31:0] WAIT_REGS_LAST = 32'h0080_0C07; // Two registers

  localparam int unsigned RAM_WAIT_RESET  = 1;
  localparam int unsigned REGS_WAIT_RESET = 0;

endpackage

`default_nettype wire

// ==== src/bus_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem (
  input  logic                clock,
  input  logic                reset_n,
  input  bus_ctrl_pkg::addr_t cpu_address,
  input  logic                cpu_read,
  input  logic                cpu_write,
  input  bus_ctrl_pkg::be_t   cpu_be,
  input  bus_ctrl_pkg::word_t cpu_writedata,
  input  bus_ctrl_pkg::addr_t vga_address,
  input  logic                vga_read,
  output logic                cpu_wait,
  output logic                vga_wait,
  output bus_ctrl_pkg::word_t cpu_readdata,
  output bus_ctrl_pkg::word_t vga_readdata
);

  bus_ctrl_pkg::addr_t       bus_address;
  logic                      bus_write;
  bus_ctrl_pkg::be_t         bus_be;
  bus_ctrl_pkg::word_t       bus_writedata;
  logic                      bus_start;
  logic                      bus_active;
  bus_map_pkg::chip_select_t chip_select;
  bus_ctrl_pkg::word_t       bus_readdata;
  bus_ctrl_pkg::word_t       ram_readdata;
  bus_ctrl_pkg::word_t       regs_readdata;
  bus_ctrl_pkg::wait_count_t wait_cycles;

  // Both masters see the shared read bus
  assign cpu_readdata = bus_readdata;
  assign vga_readdata = bus_readdata;

  bus_arbiter i_bus_arbiter (
    .clock         (clock),
    .reset_n       (reset_n),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_be        (cpu_be),
    .cpu_writedata (cpu_writedata),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .wait_cycles   (wait_cycles),
    .address       (bus_address),
    .read          (),              // Slaves return data every cycle
    .write         (bus_write),
    .be            (bus_be),
    .writedata     (bus_writedata),
    .start         (bus_start),
    .bus_active    (bus_active),
    .cpu_wait      (cpu_wait),
    .vga_wait      (vga_wait)
  );

  slave_select i_slave_select (
    .address       (bus_address),
    .bus_active    (bus_active),
    .ram_readdata  (ram_readdata),
    .regs_readdata (regs_readdata),
    .chip_select   (chip_select),
    .readdata      (bus_readdata)
  );

  wait_state_regs i_wait_state_regs (
    .clock       (clock),
    .reset_n     (reset_n),
    .address     (bus_address),
    .write       (bus_write),
    .start       (bus_start),
    .be          (bus_be),
    .writedata   (bus_writedata),
    .chip_select (chip_select),
    .readdata    (regs_readdata),
    .wait_cycles (wait_cycles)
  );

  internal_ram i_internal_ram (
    .clock       (clock),
    .address     (bus_address),
    .write       (bus_write),
    .start       (bus_start),
    .be          (bus_be),
    .writedata   (bus_writedata),
    .chip_select (chip_select),
    .readdata    (ram_readdata)
  );

endmodule

`default_nettype wire

// ==== src/internal_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module internal_ram (
  input  logic                       clock,
  input  bus_ctrl_pkg::addr_t        address,
  input  logic                       write,
  input  logic                       start,
  input  bus_ctrl_pkg::be_t          be,
  input  bus_ctrl_pkg::word_t        writedata,
  input  bus_map_pkg::chip_select_t  chip_select,
  output bus_ctrl_pkg::word_t        readdata
);

  bus_ctrl_pkg::word_t mem [bus_map_pkg::RAM_WORDS];
  logic [11:0]         word_index;
  logic                ram_write;

  assign word_index = address[13:2];
  assign ram_write  = start & write & chip_select[bus_map_pkg::CS_RAM];

  always_ff @(posedge clock) begin
    if (ram_write) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b])
          mem[word_index][8*b +: 8] <= writedata[8*b +: 8];
      end
    end
    readdata <= mem[word_index]; // Old data on a same-cycle write
  end

endmodule

`default_nettype wire

// ==== src/slave_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module slave_select (
  input  bus_ctrl_pkg::addr_t        address,
  input  logic                       bus_active,
  input  bus_ctrl_pkg::word_t        ram_readdata,
  input  bus_ctrl_pkg::word_t        regs_readdata,
  output bus_map_pkg::chip_select_t  chip_select,
  output bus_ctrl_pkg::word_t        readdata
);

  logic in_ram;
  logic in_wait_regs;

  // Offset compare, wraps for addresses below the base
  assign in_ram = (address - bus_map_pkg::RAM_BASE) <=
                  (bus_map_pkg::RAM_LAST - bus_map_pkg::RAM_BASE);
  assign in_wait_regs = (address - bus_map_pkg::WAIT_REGS_BASE) <=
                        (bus_map_pkg::WAIT_REGS_LAST - bus_map_pkg::WAIT_REGS_BASE);

  always_comb begin
    chip_select = '0;
    chip_select[bus_map_pkg::CS_RAM]       = in_ram & bus_active;
    chip_select[bus_map_pkg::CS_WAIT_REGS] = in_wait_regs & bus_active;
  end

  always_comb begin
    if (chip_select[bus_map_pkg::CS_RAM])
      readdata = ram_readdata;
    else if (chip_select[bus_map_pkg::CS_WAIT_REGS])
      readdata = regs_readdata;
    else
      readdata = '0; // Unmapped
  end

endmodule

`default_nettype wire

// ==== src/wait_state_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module wait_state_regs (
  input  logic                       clock,
  input  logic                       reset_n,
  input  bus_ctrl_pkg::addr_t        address,
  input  logic                       write,
  input  logic                       start,
  input  bus_ctrl_pkg::be_t          be,
  input  bus_ctrl_pkg::word_t        writedata,
  input  bus_map_pkg::chip_select_t  chip_select,
  output bus_ctrl_pkg::word_t        readdata,
  output bus_ctrl_pkg::wait_count_t  wait_cycles
);

  bus_ctrl_pkg::wait_count_t wait_reg [2];
  logic                      reg_index;
  logic                      reg_write;

  assign reg_index = address[2]; // Word offset 0 or 4

  // Only the low byte holds the count
  assign reg_write = start & write & chip_select[bus_map_pkg::CS_WAIT_REGS] & be[0];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      wait_reg[0] <= bus_ctrl_pkg::wait_count_t'(bus_map_pkg::RAM_WAIT_RESET);
      wait_reg[1] <= bus_ctrl_pkg::wait_count_t'(bus_map_pkg::REGS_WAIT_RESET);
    end else if (reg_write) begin
      wait_reg[reg_index] <= writedata[3:0];
    end
  end

  always_ff @(posedge clock) begin
    readdata <= {28'b0, wait_reg[reg_index]};
  end

  // RAM uses register 0, everything else register 1
  always_comb begin
    if (chip_select[bus_map_pkg::CS_RAM])
      wait_cycles = wait_reg[0];
    else
      wait_cycles = wait_reg[1];
  end

endmodule

`default_nettype wire
